// File: hw/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // request side widths
  localparam int AddrW = 32;
  localparam int XLen = 64;
  localparam int WordBytes = XLen / 8;

  // line geometry, 4 words of 64 bits
  localparam int LineWords = 4;
  localparam int LineBytes = LineWords * WordBytes;
  localparam int OffsetW = 5;
  localparam int ByteSelW = 3;
  localparam int WordSelW = OffsetW - ByteSelW;

  typedef logic [AddrW-1:0] addrT;
  typedef logic [XLen-1:0] wordT;
  typedef logic [WordBytes-1:0] maskT;

  // word view for refill and read select, byte view for masked stores
  typedef union packed {
    wordT [LineWords-1:0] words;
    logic [LineBytes-1:0][7:0] bytes;
  } lineT;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    RefillReq,
    Refill,
    Install
  } ctrlStateT;

endpackage

`default_nettype wire

// File: hw/lookupIf.sv
`timescale 1ns/1ps
`default_nettype none

interface lookupIf import dcachePkg::*; #(
  parameter int NumSets = 64
);

  localparam int IndexW = $clog2(NumSets);
  localparam int TagW = AddrW - IndexW - OffsetW;

  // driven by the controller
  logic [IndexW-1:0] index;
  logic [TagW-1:0] tag;
  logic install;
  logic markDirty;
  logic wayIn;

  // lookup result from the tag store
  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic [TagW-1:0] victimTag;

  modport ctrl (
    output index, tag, install, markDirty, wayIn,
    input hit, hitWay, victimWay, victimDirty, victimTag
  );

  modport store (
    input index, tag, install, markDirty, wayIn,
    output hit, hitWay, victimWay, victimDirty, victimTag
  );

endinterface

`default_nettype wire

// File: hw/tagStore.sv
`timescale 1ns/1ps
`default_nettype none

module tagStore import dcachePkg::*; #(
  parameter int NumSets = 64
) (
  input logic   clk,
  input logic   rst_n,
  lookupIf.store lk
);

  localparam int IndexW = $clog2(NumSets);
  localparam int TagW = AddrW - IndexW - OffsetW;

  logic [1:0][NumSets-1:0] validBits;
  logic [1:0][NumSets-1:0] dirtyBits;
  logic [TagW-1:0] tagArray [2][NumSets];
  logic replBit;
  logic [1:0] wayHit;

  // tag compare on both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][lk.index] && (tagArray[w][lk.index] == lk.tag);
    end
  end

  assign lk.hit = |wayHit;
  assign lk.hitWay = wayHit[1];

  // victim follows the replacement bit
  assign lk.victimWay = replBit;
  assign lk.victimDirty = validBits[replBit][lk.index] && dirtyBits[replBit][lk.index];
  assign lk.victimTag = tagArray[replBit][lk.index];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
      replBit <= 1'b0;
    end else if (lk.install) begin
      validBits[lk.wayIn][lk.index] <= 1'b1;
      dirtyBits[lk.wayIn][lk.index] <= 1'b0;
      replBit <= ~replBit;
    end else if (lk.markDirty) begin
      dirtyBits[lk.wayIn][lk.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lk.install) begin
      tagArray[lk.wayIn][lk.index] <= lk.tag;
    end
  end

  // refill only runs after a miss, so a tag lives in one way at most
  assert property (@(posedge clk) disable iff (!rst_n)
    !(wayHit[0] && wayHit[1]))
    else $error("both ways hit at index %0d", lk.index);

endmodule

`default_nettype wire

// File: hw/dataStore.sv
`timescale 1ns/1ps
`default_nettype none

module dataStore import dcachePkg::*; #(
  parameter int NumSets = 64,
  localparam int IndexW = $clog2(NumSets)
) (
  input  logic                 clk,
  input  logic                 weEn_i,
  input  logic                 way_i,
  input  logic [IndexW-1:0]    index_i,
  input  lineT                 line_i,
  input  logic [LineBytes-1:0] be_i,
  input  logic                 rdWay_i,
  input  logic [WordSelW-1:0]  offsetWord_i,
  output lineT                 line_o,
  output wordT                 word_o
);

  // two ways of line storage
  lineT mem [2][NumSets];

  // byte enabled write, full line on refill
  always_ff @(posedge clk) begin
    if (weEn_i) begin
      for (int b = 0; b < LineBytes; b++) begin
        if (be_i[b]) begin
          mem[way_i][index_i].bytes[b] <= line_i.bytes[b];
        end
      end
    end
  end

  // whole line for write-back
  assign line_o = mem[rdWay_i][index_i];

  // addressed word for load response
  assign word_o = line_o.words[offsetWord_i];

endmodule

`default_nettype wire

// File: hw/lineFill.sv
`timescale 1ns/1ps
`default_nettype none

module lineFill import dcachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic beatValid_i,
  input  logic beatLast_i,
  input  wordT beat_i,
  output lineT line_o,
  output logic lineDone_o
);

  logic [$clog2(LineWords)-1:0] beatCnt;
  lineT fillBuf;

  // beat position inside the line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      if (beatLast_i) begin
        beatCnt <= '0;
      end else begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      fillBuf.words[beatCnt] <= beat_i;
    end
  end

  assign line_o = fillBuf;
  assign lineDone_o = beatValid_i && beatLast_i;

  // last flag only on the fourth beat, and always on it
  assert property (@(posedge clk) disable iff (!rst_n)
    beatValid_i |-> (beatLast_i == (beatCnt == LineWords - 1)))
    else $error("refill last flag out of step with beat count %0d", beatCnt);

endmodule

`default_nettype wire

// File: hw/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl import dcachePkg::*; #(
  parameter int NumSets = 64,
  localparam int IndexW = $clog2(NumSets)
) (
  input  logic              clk,
  input  logic              rst_n,
  // front port
  input  logic              reqValid_i,
  output logic              reqReady_o,
  input  logic              reqWrite_i,
  input  addrT              reqAddr_i,
  input  wordT              reqWdata_i,
  input  maskT              reqWmask_i,
  output logic              respValid_o,
  // tag store
  lookupIf.ctrl             lk,
  // data store
  output logic              dataWe_o,
  output logic              dataWay_o,
  output logic [IndexW-1:0] dataIndex_o,
  output logic [WordSelW-1:0] dataOffset_o,
  output lineT              dataLine_o,
  output logic [LineBytes-1:0] dataBe_o,
  input  lineT              rdLine_i,
  // refill buffer
  input  logic              lineDone_i,
  input  lineT              fillLine_i,
  // memory bus
  output logic              memRdValid_o,
  output addrT              memRdAddr_o,
  input  logic              memRdReady_i,
  output logic              memWrValid_o,
  output addrT              memWrAddr_o,
  output lineT              memWrData_o,
  input  logic              memWrReady_i
);

  localparam int TagW = AddrW - IndexW - OffsetW;

  ctrlStateT state, stateNext;
  addrT addrQ;
  logic writeQ;
  wordT wdataQ;
  maskT wmaskQ;
  logic [WordSelW-1:0] wordSel;
  logic storeHit;
  lineT storeLine;
  logic [LineBytes-1:0] storeBe;

  // request latch, one request in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addrQ <= '0;
      writeQ <= 1'b0;
      wdataQ <= '0;
      wmaskQ <= '0;
    end else if (reqValid_i && reqReady_o) begin
      addrQ <= reqAddr_i;
      writeQ <= reqWrite_i;
      wdataQ <= reqWdata_i;
      wmaskQ <= reqWmask_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle: begin
        if (reqValid_i) begin
          stateNext = Lookup;
        end
      end
      Lookup: begin
        if (lk.hit) begin
          stateNext = Idle;
        end else if (lk.victimDirty) begin
          stateNext = WriteBack;
        end else begin
          stateNext = RefillReq;
        end
      end
      WriteBack: begin
        if (memWrReady_i) begin
          stateNext = RefillReq;
        end
      end
      RefillReq: begin
        if (memRdReady_i) begin
          stateNext = Refill;
        end
      end
      Refill: begin
        if (lineDone_i) begin
          stateNext = Install;
        end
      end
      Install: stateNext = Lookup;
      default: stateNext = Idle;
    endcase
  end

  assign wordSel = addrQ[ByteSelW +: WordSelW];

  // place store word and mask at their word slot in the line
  always_comb begin
    storeLine = '0;
    storeBe = '0;
    for (int b = 0; b < WordBytes; b++) begin
      storeLine.bytes[wordSel * WordBytes + b] = wdataQ[8 * b +: 8];
      storeBe[wordSel * WordBytes + b] = wmaskQ[b];
    end
  end

  assign lk.index = addrQ[OffsetW +: IndexW];
  assign lk.tag = addrQ[AddrW-1 -: TagW];

  assign storeHit = (state == Lookup) && lk.hit && writeQ;
  assign lk.markDirty = storeHit;
  assign lk.install = (state == Install);

  // hit way while looking up, victim way otherwise
  assign dataWay_o = (state == Lookup) ? lk.hitWay : lk.victimWay;
  assign lk.wayIn = dataWay_o;

  assign dataWe_o = storeHit || (state == Install);
  assign dataIndex_o = lk.index;
  assign dataOffset_o = wordSel;
  assign dataLine_o = (state == Install) ? fillLine_i : storeLine;
  assign dataBe_o = (state == Install) ? '1 : storeBe;

  assign reqReady_o = (state == Idle);
  assign respValid_o = (state == Lookup) && lk.hit;

  assign memRdValid_o = (state == RefillReq);
  assign memRdAddr_o = {addrQ[AddrW-1:OffsetW], {OffsetW{1'b0}}};

  // victim line address rebuilt from its stored tag
  assign memWrValid_o = (state == WriteBack);
  assign memWrAddr_o = {lk.victimTag, lk.index, {OffsetW{1'b0}}};
  assign memWrData_o = rdLine_i;

  assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_o && memWrValid_o))
    else $error("read and write bus requests raised together");

  // a freshly installed line must hit on the following lookup
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == Install) |=> lk.hit)
    else $error("lookup after install did not hit");

endmodule

`default_nettype wire

// File: hw/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop import dcachePkg::*; #(
  parameter int NumSets = 64
) (
  input  logic clk,
  input  logic rst_n,
  // load/store request port
  input  logic reqValid_i,
  output logic reqReady_o,
  input  logic reqWrite_i,
  input  addrT reqAddr_i,
  input  wordT reqWdata_i,
  input  maskT reqWmask_i,
  output logic respValid_o,
  output wordT respRdata_o,
  // line refill
  output logic memRdValid_o,
  output addrT memRdAddr_o,
  input  logic memRdReady_i,
  input  logic memRdDataValid_i,
  input  logic memRdLast_i,
  input  wordT memRdData_i,
  // victim write-back
  output logic memWrValid_o,
  output addrT memWrAddr_o,
  output lineT memWrData_o,
  input  logic memWrReady_i
);

  localparam int IndexW = $clog2(NumSets);

  logic dataWe;
  logic dataWay;
  logic [IndexW-1:0] dataIndex;
  logic [WordSelW-1:0] dataOffset;
  lineT dataLine;
  logic [LineBytes-1:0] dataBe;
  lineT rdLine;
  lineT fillLine;
  logic lineDone;

  lookupIf #(.NumSets(NumSets)) lk ();

  cacheCtrl #(.NumSets(NumSets)) uCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqReady_o   (reqReady_o),
    .reqWrite_i   (reqWrite_i),
    .reqAddr_i    (reqAddr_i),
    .reqWdata_i   (reqWdata_i),
    .reqWmask_i   (reqWmask_i),
    .respValid_o  (respValid_o),
    .lk           (lk.ctrl),
    .dataWe_o     (dataWe),
    .dataWay_o    (dataWay),
    .dataIndex_o  (dataIndex),
    .dataOffset_o (dataOffset),
    .dataLine_o   (dataLine),
    .dataBe_o     (dataBe),
    .rdLine_i     (rdLine),
    .lineDone_i   (lineDone),
    .fillLine_i   (fillLine),
    .memRdValid_o (memRdValid_o),
    .memRdAddr_o  (memRdAddr_o),
    .memRdReady_i (memRdReady_i),
    .memWrValid_o (memWrValid_o),
    .memWrAddr_o  (memWrAddr_o),
    .memWrData_o  (memWrData_o),
    .memWrReady_i (memWrReady_i)
  );

  tagStore #(.NumSets(NumSets)) uTags (
    .clk   (clk),
    .rst_n (rst_n),
    .lk    (lk.store)
  );

  // one way select serves both the write and the read side
  dataStore #(.NumSets(NumSets)) uData (
    .clk          (clk),
    .weEn_i       (dataWe),
    .way_i        (dataWay),
    .index_i      (dataIndex),
    .line_i       (dataLine),
    .be_i         (dataBe),
    .rdWay_i      (dataWay),
    .offsetWord_i (dataOffset),
    .line_o       (rdLine),
    .word_o       (respRdata_o)
  );

  lineFill uFill (
    .clk         (clk),
    .rst_n       (rst_n),
    .beatValid_i (memRdDataValid_i),
    .beatLast_i  (memRdLast_i),
    .beat_i      (memRdData_i),
    .line_o      (fillLine),
    .lineDone_o  (lineDone)
  );

endmodule

`default_nettype wire

// File: bench/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel import dcachePkg::*; #(
  parameter addrT WinBase = 32'h8000_0000,
  parameter int WinBytes = 16384,
  parameter logic [31:0] Seed = 32'h66dd1c5e
) (
  input  logic clk,
  input  logic rdValid_i,
  input  addrT rdAddr_i,
  output logic rdReady_o,
  output logic beatValid_o,
  output logic beatLast_o,
  output wordT beatData_o,
  input  logic wrValid_i,
  input  addrT wrAddr_i,
  input  lineT wrData_i,
  output logic wrReady_o,
  output logic rangeErr_o
);

  localparam int WinWords = WinBytes / WordBytes;

  wordT mem [WinWords];
  logic [31:0] rngState;
  addrT lineAddr;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every address bit feeds the initial word
  function automatic wordT patternWord(input addrT a);
    return {a ^ 32'hc3a5_96e1, {a[15:0], a[31:16]} ^ ~a};
  endfunction

  function automatic bit inWindow(input addrT a);
    return addrT'(a - WinBase) < addrT'(WinBytes);
  endfunction

  function automatic int wordIdx(input addrT a);
    return int'(addrT'(a - WinBase) >> ByteSelW);
  endfunction

  initial begin
    for (int i = 0; i < WinWords; i++) begin
      mem[i] = patternWord(WinBase + addrT'(i * WordBytes));
    end
    rngState = Seed;
    rdReady_o = 1'b0;
    beatValid_o = 1'b0;
    beatLast_o = 1'b0;
    beatData_o = '0;
    wrReady_o = 1'b0;
    rangeErr_o = 1'b0;
    forever begin
      @(negedge clk);
      if (wrValid_i) begin
        rngState = xorshift32(rngState);
        repeat (rngState[1:0]) @(negedge clk);
        if (inWindow(wrAddr_i)) begin
          for (int w = 0; w < LineWords; w++) begin
            mem[wordIdx(wrAddr_i) + w] = wrData_i.words[w];
          end
        end else begin
          rangeErr_o = 1'b1;
        end
        wrReady_o = 1'b1;
        @(negedge clk);
        wrReady_o = 1'b0;
      end else if (rdValid_i) begin
        rngState = xorshift32(rngState);
        repeat (rngState[1:0]) @(negedge clk);
        lineAddr = rdAddr_i;
        if (!inWindow(lineAddr)) begin
          rangeErr_o = 1'b1;
        end
        rdReady_o = 1'b1;
        @(negedge clk);
        rdReady_o = 1'b0;
        // four beats, with an idle cycle now and then
        for (int w = 0; w < LineWords; w++) begin
          beatValid_o = 1'b1;
          beatLast_o = (w == LineWords - 1);
          beatData_o = inWindow(lineAddr) ? mem[wordIdx(lineAddr) + w] : '0;
          @(negedge clk);
          beatValid_o = 1'b0;
          beatLast_o = 1'b0;
          rngState = xorshift32(rngState);
          if (rngState[2] && (w < LineWords - 1)) begin
            @(negedge clk);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb import dcachePkg::*; ();

  localparam int NumSets = 64;
  localparam addrT WinBase = 32'h8000_0000;
  localparam int WinBytes = 16384;
  localparam logic [31:0] RandSeed = 32'h66dd1c5e;
  localparam int ResetCycles = 8;
  localparam int DirectedReqs = 12;
  localparam int RandomReqs = 300;
  localparam int CycleLimit = (DirectedReqs + RandomReqs) * 40;
  localparam int SetStride = NumSets * LineBytes;

  logic clk;
  logic rst_n;
  logic reqValid;
  logic reqReady;
  logic reqWrite;
  addrT reqAddr;
  wordT reqWdata;
  maskT reqWmask;
  logic respValid;
  wordT respRdata;
  logic memRdValid;
  addrT memRdAddr;
  logic memRdReady;
  logic memRdDataValid;
  logic memRdLast;
  wordT memRdData;
  logic memWrValid;
  addrT memWrAddr;
  lineT memWrData;
  logic memWrReady;
  logic rangeErr;

  logic [7:0] shadow [WinBytes];
  bit touched [WinBytes];
  logic [31:0] rngState;
  int reqCount = 0;
  int respCount = 0;
  int cycleCnt = 0;
  addrT wbAddrQ [$];

  dcacheTop #(.NumSets(NumSets)) u_dcacheTop (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqReady_o(reqReady), .reqWrite_i(reqWrite),
    .reqAddr_i(reqAddr), .reqWdata_i(reqWdata), .reqWmask_i(reqWmask),
    .respValid_o(respValid), .respRdata_o(respRdata),
    .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr), .memRdReady_i(memRdReady),
    .memRdDataValid_i(memRdDataValid), .memRdLast_i(memRdLast), .memRdData_i(memRdData),
    .memWrValid_o(memWrValid), .memWrAddr_o(memWrAddr), .memWrData_o(memWrData),
    .memWrReady_i(memWrReady)
  );

  memModel #(.WinBase(WinBase), .WinBytes(WinBytes), .Seed(RandSeed)) uMem (
    .clk(clk), .rdValid_i(memRdValid), .rdAddr_i(memRdAddr), .rdReady_o(memRdReady),
    .beatValid_o(memRdDataValid), .beatLast_o(memRdLast), .beatData_o(memRdData),
    .wrValid_i(memWrValid), .wrAddr_i(memWrAddr), .wrData_i(memWrData),
    .wrReady_o(memWrReady), .rangeErr_o(rangeErr)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // same address rule as the memory's initial contents
  function automatic wordT patternWord(input addrT a);
    return {a ^ 32'hc3a5_96e1, {a[15:0], a[31:16]} ^ ~a};
  endfunction

  // expected load word from the initial pattern and all stores so far
  function automatic wordT refLoad(input addrT addr);
    addrT base;
    wordT init;
    wordT r;
    int idx;
    base = {addr[AddrW-1:ByteSelW], {ByteSelW{1'b0}}};
    init = patternWord(base);
    idx = int'(base - WinBase);
    for (int b = 0; b < WordBytes; b++) begin
      r[8*b +: 8] = touched[idx + b] ? shadow[idx + b] : init[8*b +: 8];
    end
    return r;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkWord(input wordT got, input wordT exp, input string what);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic checkAddr(input addrT got, input addrT exp, input string what);
    if (got !== exp) begin
      abortRun($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                         $time, what, got, exp));
    end
  endtask

  task automatic recordStore(input addrT addr, input wordT data, input maskT mask);
    int idx;
    idx = int'({addr[AddrW-1:ByteSelW], {ByteSelW{1'b0}}} - WinBase);
    for (int b = 0; b < WordBytes; b++) begin
      if (mask[b]) begin
        shadow[idx + b] = data[8*b +: 8];
        touched[idx + b] = 1'b1;
      end
    end
  endtask

  // called on a falling edge, returns on the falling edge of the response
  task automatic issueRequest(input logic write, input addrT addr, input wordT wdata,
                              input maskT wmask, output wordT rdata, output int latency);
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    reqWdata = wdata;
    reqWmask = wmask;
    while (!reqReady) begin
      @(negedge clk);
    end
    @(negedge clk);
    reqValid = 1'b0;
    reqCount++;
    if (write) begin
      recordStore(addr, wdata, wmask);
    end
    latency = 1;
    while (!respValid) begin
      @(negedge clk);
      latency++;
    end
    rdata = respRdata;
  endtask

  task automatic loadAndCheck(input addrT addr, output int latency);
    wordT rdata;
    issueRequest(1'b0, addr, '0, '0, rdata, latency);
    checkWord(rdata, refLoad(addr), $sformatf("load from %h", addr));
  endtask

  task automatic storeWord(input addrT addr, input wordT data, input maskT mask);
    wordT rdata;
    int latency;
    issueRequest(1'b1, addr, data, mask, rdata, latency);
  endtask

  always @(negedge clk) begin
    if (respValid) begin
      respCount++;
    end
    if (rangeErr) begin
      abortRun("memory model saw an address outside the test window");
    end
  end

  always @(posedge clk) begin
    if (memWrValid && memWrReady) begin
      wbAddrQ.push_back(memWrAddr);
    end
    cycleCnt++;
    if (cycleCnt > CycleLimit) begin
      abortRun($sformatf("timeout after %0d cycles", cycleCnt));
    end
  end

  initial begin
    int lat;
    logic [31:0] r;
    addrT a;
    addrT aLine;
    addrT bLine;
    addrT cLine;
    clk = 1'b0;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    reqWmask = '0;
    rngState = RandSeed;
    for (int i = 0; i < WinBytes; i++) begin
      shadow[i] = 8'h00;
      touched[i] = 1'b0;
    end
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    if (!reqReady || respValid || memRdValid || memWrValid) begin
      abortRun("outputs after reset are not idle");
    end

    // cold miss, then a hit in the same line
    loadAndCheck(WinBase + 32'h40, lat);
    if (lat <= 1) begin
      abortRun("first load answered without a refill");
    end
    loadAndCheck(WinBase + 32'h58, lat);
    if (lat != 1) begin
      abortRun($sformatf("hit took %0d cycles instead of 1", lat));
    end

    // byte merge
    storeWord(WinBase + 32'h48, 64'h0123_4567_89ab_cdef, 8'b1010_0110);
    loadAndCheck(WinBase + 32'h48, lat);

    // three lines in set 40, two of them dirty
    aLine = WinBase + addrT'(40 * LineBytes);
    bLine = aLine + addrT'(SetStride);
    cLine = aLine + addrT'(2 * SetStride);
    wbAddrQ.delete();
    loadAndCheck(aLine + 8, lat);
    storeWord(aLine + 8, {nextRand(), nextRand()}, 8'hff);
    loadAndCheck(bLine, lat);
    storeWord(bLine + 16, {nextRand(), nextRand()}, 8'h0f);
    loadAndCheck(cLine + 24, lat);
    if (wbAddrQ.size() != 1) begin
      abortRun($sformatf("%0d write-backs after the first eviction", wbAddrQ.size()));
    end
    checkAddr(wbAddrQ[0], aLine, "first write-back address");
    loadAndCheck(aLine + 8, lat);
    if (wbAddrQ.size() != 2) begin
      abortRun($sformatf("%0d write-backs after the second eviction", wbAddrQ.size()));
    end
    checkAddr(wbAddrQ[1], bLine, "second write-back address");
    loadAndCheck(bLine + 16, lat);
    loadAndCheck(cLine + 24, lat);

    // random traffic over 8 sets with 4 tags each
    for (int n = 0; n < RandomReqs; n++) begin
      r = nextRand();
      a = WinBase | (addrT'(r[12:11]) << 11) | (addrT'(r[7:5]) << 5)
                  | (addrT'(r[4:3]) << 3);
      if (r[31]) begin
        storeWord(a, {nextRand(), nextRand()}, r[23:16]);
      end else begin
        loadAndCheck(a, lat);
      end
    end

    repeat (5) @(negedge clk);
    if (respCount != reqCount) begin
      abortRun($sformatf("%0d responses for %0d requests", respCount, reqCount));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/dcachePkg.sv
hw/lookupIf.sv
hw/tagStore.sv
hw/dataStore.sv
hw/lineFill.sv
hw/cacheCtrl.sv
hw/dcacheTop.sv
bench/memModel.sv
bench/dcacheTb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - hw/dcachePkg.sv
      - hw/lookupIf.sv
      - hw/tagStore.sv
      - hw/dataStore.sv
      - hw/lineFill.sv
      - hw/cacheCtrl.sv
      - hw/dcacheTop.sv
  - target: simulation
    files:
      - bench/memModel.sv
      - bench/dcacheTb.sv
